// File: Makefile
# Verilator build and run of the execute slice testbench

VERILATOR ?= verilator
TOP       ?= r5p_exec_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: r5p_alu.sv
/*
  Integer ALU, purely combinational. Branch codes give zero.
  Shift amount is the low five bits of opb.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_alu
  import r5p_isa_pkg::*;
(
  input  r5p_op_t              op,
  input  logic [`R5P_XLEN-1:0] rs1_val,
  input  logic [`R5P_XLEN-1:0] opb,      // rs2 value or immediate
  output logic [`R5P_XLEN-1:0] result
);

  localparam int unsigned XLEN = `R5P_XLEN;

  logic [4:0] shamt;
  logic       lt_s;     // Signed less-than
  logic       lt_u;     // Unsigned less-than

  assign shamt = opb[4:0];
  assign lt_s  = $signed(rs1_val) < $signed(opb);
  assign lt_u  = rs1_val < opb;

  always_comb begin
    case (op)
      op_add:  result = rs1_val + opb;
      op_sub:  result = rs1_val - opb;
      op_and:  result = rs1_val & opb;
      op_or:   result = rs1_val | opb;
      op_xor:  result = rs1_val ^ opb;
      // Compare results are 0 or 1
      op_slt:  result = {{(XLEN-1){1'b0}}, lt_s};
      op_sltu: result = {{(XLEN-1){1'b0}}, lt_u};
      // Shifts
      op_sll:  result = rs1_val << shamt;
      op_srl:  result = rs1_val >> shamt;
      op_sra:  result = $unsigned($signed(rs1_val) >>> shamt);  // Sign fill
      default: result = '0;              // Branches
    endcase
  end

endmodule

// File: r5p_branch.sv
/*
  Branch comparator and target adder, combinational.
  Target is always pc + imm, even when not taken or for ALU codes.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_branch
  import r5p_isa_pkg::*;
(
  input  r5p_op_t              op,
  input  logic [`R5P_XLEN-1:0] rs1_val,
  input  logic [`R5P_XLEN-1:0] rs2_val,
  input  logic [`R5P_XLEN-1:0] pc,
  input  logic [`R5P_XLEN-1:0] imm,
  output logic                 taken,
  output logic [`R5P_XLEN-1:0] target
);

  logic eq;
  logic lt;

  assign eq = (rs1_val == rs2_val);

  // One comparator, signedness picked by op
  assign lt = r5p_is_signed(op) ? ($signed(rs1_val) < $signed(rs2_val))
                                : (rs1_val < rs2_val);

  always_comb begin
    case (op)
      op_beq:           taken = eq;
      op_bne:           taken = ~eq;
      op_blt, op_bltu:  taken = lt;
      op_bge, op_bgeu:  taken = ~lt;
      default:          taken = 1'b0;   // ALU ops never branch
    endcase
  end

  assign target = pc + imm;

endmodule

// File: r5p_credit_fifo.sv
/*
  Synchronous FIFO with a combinational head. DEPTH must be a power of two, 2 or more.
  A push while full is dropped, so the writer must respect the returned credits.
*/

`timescale 1ns/1ps

module r5p_credit_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
)(
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic not_empty,
  output logic full,
  output logic credit      // One cycle per popped entry
);

  localparam int unsigned PW = $clog2(DEPTH);
  localparam logic [PW:0] FULL_CNT = DEPTH[PW:0];

  T            mem [DEPTH];
  logic [PW:0] wr_ptr;     // Extra bit tells full from empty
  logic [PW:0] rd_ptr;
  logic [PW:0] count;
  logic        do_push;
  logic        do_pop;

  assign count     = wr_ptr - rd_ptr;
  assign not_empty = (count != '0);
  assign full      = (count == FULL_CNT);
  assign do_push   = push & ~full;
  assign do_pop    = pop & not_empty;   // Pop on empty is ignored

  assign pop_data = mem[rd_ptr[PW-1:0]];  // Head, no read latency

  // Pointers and the credit pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      credit <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      credit <= do_pop;                  // Registered, cycle after pop
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr[PW-1:0]] <= push_data;
  end

endmodule

// File: r5p_exec_checker.sv
/*
  Protocol checks on the execute slice ports, bound to the top level.
  Assumes the sink never holds more than R5P_OUT_CREDITS credits.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_exec_checker
  import r5p_stream_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        in_valid,
  input logic        in_credit,
  input logic        out_valid,
  input r5p_result_t out_result,
  input logic        out_credit
);

  logic [3:0]  sink_cnt;              // Shadow of the sink credit counter
  logic [7:0]  in_pend;               // Pushes not yet credited back
  logic [7:0]  last_tag;
  logic        tag_seen;
  int unsigned fail_count = 0;        // Read by the testbench

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sink_cnt <= 4'(`R5P_OUT_CREDITS);
      in_pend  <= '0;
      last_tag <= '0;
      tag_seen <= 1'b0;
    end else begin
      sink_cnt <= sink_cnt + 4'(out_credit) - 4'(out_valid);
      in_pend  <= in_pend + 8'(in_valid) - 8'(in_credit);
      if (out_valid) begin
        last_tag <= out_result.tag;
        tag_seen <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Quiet outputs right after reset
  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (!out_valid && !in_credit))
    else begin fail_count++; $error("out_valid or in_credit high after reset"); end

  a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> (sink_cnt != '0))
    else begin fail_count++; $error("out_valid without an output credit"); end

  // Each credit needs an earlier push
  a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_credit |-> (in_pend != '0))
    else begin fail_count++; $error("in_credit without a matching push"); end

  a_tag_order: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && tag_seen) |-> (out_result.tag == last_tag + 8'd1))
    else begin fail_count++; $error("result tags out of order"); end

endmodule

// File: r5p_exec_tb.sv
/*
  Random credit-driven test of the execute slice with a sequential reference model.
  Register indices stay in x0..x7 so dependences and x0 writes come up often.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_exec_tb
  import r5p_isa_pkg::*;
  import r5p_stream_pkg::*;
;

  localparam int unsigned XLEN    = `R5P_XLEN;
  localparam int          N_INSTR = 300;              // Tags wrap past 256
  localparam int          TIMEOUT = 40 * N_INSTR;     // Cycles

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  r5p_instr_t  in_instr;
  logic        in_credit;
  logic        out_valid;
  r5p_result_t out_result;
  logic        out_credit;

  integer          seed;
  logic [XLEN-1:0] regs [32];         // Reference register file
  r5p_result_t     exp_q [$];         // Expected results in issue order
  r5p_result_t     exp_res;
  r5p_instr_t      next_instr;
  logic [31:0]     rnd;
  int              sent;
  int              cycles;
  int              src_credits;       // Source side view of input credits
  int              owed;              // Sink credits not yet returned
  int              hold;              // Cycles left in a withholding stretch
  int              stray;             // Results seen after the last expected one
  logic [4:0]      prev_rd;

  r5p_exec_top u_r5p_exec_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_instr   (in_instr),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  bind r5p_exec_top r5p_exec_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;            // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Random instruction, rs1 often reuses the previous rd
  task automatic make_instr(output r5p_instr_t ins);
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [3:0]  pick;
    r1   = $random(seed);
    r2   = $random(seed);
    r3   = $random(seed);
    pick = r1[3:0];
    ins  = '0;
    ins.tag = sent[7:0];
    if (pick < 4'd10) ins.op = r5p_op_t'({1'b0, pick});
    else ins.op = r5p_op_t'(5'h10 + {1'b0, pick - 4'd10});   // beq..bgeu
    ins.rd  = {2'b00, r1[6:4]};
    ins.rs1 = r1[7] ? prev_rd : {2'b00, r1[10:8]};
    ins.rs2 = {2'b00, r1[13:11]};
    ins.pc  = {r3[31:2], 2'b00};
    if (pick >= 4'd10) begin
      ins.use_imm = 1'b0;                         // Branches compare two registers
      ins.imm     = {{19{r2[12]}}, r2[12:1], 1'b0};
    end else begin
      ins.use_imm = r1[14];
      case (r1[16:15])
        2'd0:    ins.imm = {29'b0, r2[2:0]};      // Small, hits equal compares
        2'd3:    ins.imm = r2;                     // Full range
        default: ins.imm = {{20{r2[11]}}, r2[11:0]};
      endcase
    end
    prev_rd = ins.rd;
  endtask

  // Executes one instruction in program order and queues its result
  task automatic predict(input r5p_instr_t ins);
    r5p_result_t     r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] opb;
    logic            br;
    a   = regs[ins.rs1];
    b   = regs[ins.rs2];
    opb = ins.use_imm ? ins.imm : b;
    br  = 1'b0;
    r        = '0;
    r.tag    = ins.tag;
    r.rd     = ins.rd;
    r.target = ins.pc + ins.imm;                  // Whatever the outcome
    case (ins.op)
      op_add:  r.data = a + opb;
      op_sub:  r.data = a - opb;
      op_and:  r.data = a & opb;
      op_or:   r.data = a | opb;
      op_xor:  r.data = a ^ opb;
      op_slt:  r.data[0] = $signed(a) < $signed(opb);
      op_sltu: r.data[0] = a < opb;
      op_sll:  r.data = a << opb[4:0];
      op_srl:  r.data = a >> opb[4:0];
      op_sra:  r.data = $unsigned($signed(a) >>> opb[4:0]);
      op_beq:  begin br = 1'b1; r.taken = (a == b); end
      op_bne:  begin br = 1'b1; r.taken = (a != b); end
      op_blt:  begin br = 1'b1; r.taken = $signed(a) < $signed(b); end
      op_bge:  begin br = 1'b1; r.taken = $signed(a) >= $signed(b); end
      op_bltu: begin br = 1'b1; r.taken = a < b; end
      op_bgeu: begin br = 1'b1; r.taken = a >= b; end
      default: ;
    endcase
    r.wen = !br && (ins.rd != '0);                 // x0 and branches write nothing
    if (r.wen) regs[ins.rd] = r.data;
    exp_q.push_back(r);
  endtask

  // Name of the first field that differs
  function automatic string diff_field(input r5p_result_t got, input r5p_result_t exp);
    if (got.tag != exp.tag) return "tag";
    if (got.rd != exp.rd) return "rd";
    if (got.wen != exp.wen) return "wen";
    if (got.data != exp.data) return "data";
    if (got.taken != exp.taken) return "taken";
    if (got.target != exp.target) return "target";
    return "unknown";
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Main loop, sample then drive 1 ns after each rising edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 55;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_instr    = '0;
    out_credit  = 1'b0;
    sent        = 0;
    cycles      = 0;
    src_credits = `R5P_IN_DEPTH;
    owed        = 0;
    hold        = 0;
    stray       = 0;
    prev_rd     = '0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    while (sent < N_INSTR || exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout after %0d cycles, %0d results still missing", cycles, exp_q.size());
        $display(">>> FAIL");
        $fatal(1, "Pipeline did not drain in time");
      end else if (u_r5p_exec_top.u_checker.fail_count != 0) begin
        $display("Protocol checker reported a violation at %0t", $time);
        $display(">>> FAIL");
        $fatal(1, "Checker assertion failed");
      end else begin
        if (in_credit) src_credits++;
        if (out_valid) begin
          if (exp_q.size() == 0) begin
            $display("Result tag %0d at %0t with nothing outstanding", out_result.tag, $time);
            $display(">>> FAIL");
            $fatal(1, "Unexpected result");
          end else begin
            exp_res = exp_q.pop_front();
            assert (out_result === exp_res) else begin
              $display("** Error at %0t ns: tag %0d field %s got %h expected %h", $time,
                       exp_res.tag, diff_field(out_result, exp_res), out_result, exp_res);
              $display(">>> FAIL");
              $fatal(1, "Result mismatch");
            end
            owed++;
          end
        end
        // Sink, sometimes holds credits for a stretch
        rnd = $random(seed);
        out_credit = 1'b0;
        if (hold != 0) hold--;
        else if (rnd[7:4] == 4'd0) hold = 5 + int'(rnd[12:8]);
        else if (owed > 0 && rnd[1:0] != 2'd0) begin
          out_credit = 1'b1;
          owed--;
        end
        // Source, only while credits remain
        in_valid = 1'b0;
        if (sent < N_INSTR && src_credits > 0 && rnd[15:13] != 3'd0) begin
          make_instr(next_instr);
          predict(next_instr);
          in_instr = next_instr;
          in_valid = 1'b1;
          src_credits--;
          sent++;
        end
      end
    end

    in_valid   = 1'b0;
    out_credit = 1'b0;
    // Let the checker see the last edges, no result may follow the last one
    repeat (2) begin
      @(posedge clk);
      #1;
      if (out_valid) stray++;
    end
    if (stray == 0 && u_r5p_exec_top.u_checker.fail_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "Extra result or checker failure at end of run");
    end
  end

endmodule

// File: r5p_exec_top.sv
/*
  Execute slice top. Both streams use credits, the source starts with R5P_IN_DEPTH.
  Latency from in_valid to out_valid is 3 cycles with no back-pressure.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_exec_top
  import r5p_stream_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // Instruction stream
  input  logic        in_valid,
  input  r5p_instr_t  in_instr,
  output logic        in_credit,
  // Result stream
  output logic        out_valid,
  output r5p_result_t out_result,
  input  logic        out_credit
);

  r5p_instr_t           head;            // Input FIFO head, the issuing instruction
  logic                 head_valid;
  logic                 issue_ready;
  logic                 rs2_en;
  logic [`R5P_XLEN-1:0] rs1_raw;
  logic [`R5P_XLEN-1:0] rs2_raw;
  logic [`R5P_XLEN-1:0] rs1_fwd;
  logic [`R5P_XLEN-1:0] rs2_fwd;
  logic [`R5P_XLEN-1:0] alu_opb;
  logic [`R5P_XLEN-1:0] alu_result;
  logic                 br_taken;
  logic [`R5P_XLEN-1:0] br_target;
  logic                 wb_en;
  logic [`R5P_AW-1:0]   wb_rd;
  logic [`R5P_XLEN-1:0] wb_data;
  logic                 res_push;
  r5p_result_t          res_data;
  logic                 res_full;
  logic                 res_not_empty;
  logic                 out_ok;
  logic                 out_fire;

  assign rs2_en    = ~head.use_imm;
  assign alu_opb   = head.use_imm ? head.imm : rs2_fwd;
  assign out_fire  = res_not_empty & out_ok;   // Spends one sink credit
  assign out_valid = out_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  r5p_credit_fifo #(
    .T     (r5p_instr_t),
    .DEPTH (`R5P_IN_DEPTH)
  ) u_in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (in_valid),
    .push_data (in_instr),
    .pop       (issue_ready),     // Ignored while empty
    .pop_data  (head),
    .not_empty (head_valid),
    .full      (),                // Source credits bound the fill level
    .credit    (in_credit)
  );

  r5p_gpr u_gpr (
    .clk   (clk),
    .rst_n (rst_n),
    .e_rs1 (head_valid),
    .e_rs2 (rs2_en),
    .e_rd  (wb_en),
    .a_rs1 (head.rs1),
    .a_rs2 (head.rs2),
    .a_rd  (wb_rd),
    .d_rs1 (rs1_raw),
    .d_rs2 (rs2_raw),
    .d_rd  (wb_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute units
  ////////////////////////////////////////////////////////////////////////////

  r5p_alu u_alu (
    .op      (head.op),
    .rs1_val (rs1_fwd),
    .opb     (alu_opb),
    .result  (alu_result)
  );

  r5p_branch u_branch (
    .op      (head.op),
    .rs1_val (rs1_fwd),
    .rs2_val (rs2_fwd),
    .pc      (head.pc),
    .imm     (head.imm),
    .taken   (br_taken),
    .target  (br_target)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Writeback and output side
  ////////////////////////////////////////////////////////////////////////////

  r5p_writeback u_wb (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (head_valid),
    .issue_instr (head),
    .issue_ready (issue_ready),
    .rs1_raw     (rs1_raw),
    .rs2_raw     (rs2_raw),
    .rs1_fwd     (rs1_fwd),
    .rs2_fwd     (rs2_fwd),
    .alu_result  (alu_result),
    .br_taken    (br_taken),
    .br_target   (br_target),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .res_full    (res_full),
    .res_push    (res_push),
    .res_data    (res_data),
    .out_fire    (out_fire),
    .out_credit  (out_credit),
    .out_ok      (out_ok)
  );

  // Sink credits live in writeback, so no credit port here
  r5p_credit_fifo #(
    .T     (r5p_result_t),
    .DEPTH (`R5P_RES_DEPTH)
  ) u_res_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (res_push),
    .push_data (res_data),
    .pop       (out_fire),
    .pop_data  (out_result),
    .not_empty (res_not_empty),
    .full      (res_full),
    .credit    ()
  );

endmodule

// File: r5p_gpr.sv
/*
  RV32I register file, inferred array only. x0 is not stored and reads zero.
  Reads are combinational, so a same-cycle write is seen only through the bypass.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_gpr (
  input  logic                 clk,
  input  logic                 rst_n,
  // Read and write enables
  input  logic                 e_rs1,
  input  logic                 e_rs2,
  input  logic                 e_rd,
  // Addresses
  input  logic [`R5P_AW-1:0]   a_rs1,
  input  logic [`R5P_AW-1:0]   a_rs2,
  input  logic [`R5P_AW-1:0]   a_rd,
  // Data
  output logic [`R5P_XLEN-1:0] d_rs1,
  output logic [`R5P_XLEN-1:0] d_rs2,
  input  logic [`R5P_XLEN-1:0] d_rd
);

  localparam int unsigned XLEN = `R5P_XLEN;
  localparam int unsigned NREG = 2**`R5P_AW;

  logic [XLEN-1:0] gpr [1:NREG-1];   // x1..x31
  logic            wen;

  // Writes to x0 vanish here
  assign wen = e_rd & |a_rd;

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NREG; i++) begin
        gpr[i] <= '0;                    // All registers read zero after reset
      end
    end else if (wen) begin
      gpr[a_rd] <= d_rd;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  // Zero when disabled or addressing x0
  assign d_rs1 = (e_rs1 & |a_rs1) ? gpr[a_rs1] : '0;
  assign d_rs2 = (e_rs2 & |a_rs2) ? gpr[a_rs2] : '0;

endmodule

// File: r5p_isa_pkg.sv
/*
  Operation encoding of the execute slice. Bit 4 of the code marks a branch.
  Only register, immediate and branch operations are covered.
*/

package r5p_isa_pkg;

  // ALU operations in the low half of the code space
  typedef enum logic [4:0] {
    op_add  = 5'h00,
    op_sub  = 5'h01,
    op_and  = 5'h02,
    op_or   = 5'h03,
    op_xor  = 5'h04,
    op_slt  = 5'h05,
    op_sltu = 5'h06,
    op_sll  = 5'h07,
    op_srl  = 5'h08,
    op_sra  = 5'h09,
    // Branches, bit 4 set
    op_beq  = 5'h10,
    op_bne  = 5'h11,
    op_blt  = 5'h12,
    op_bge  = 5'h13,
    op_bltu = 5'h14,
    op_bgeu = 5'h15
  } r5p_op_t;

  // Branch class straight from the encoding
  function automatic logic r5p_is_branch(r5p_op_t op);
    return op[4];
  endfunction

  // Signed compare for blt and bge only
  function automatic logic r5p_is_signed(r5p_op_t op);
    return (op == op_blt) || (op == op_bge);
  endfunction

endpackage

// File: r5p_settings.svh
/*
  Shared sizes for the execute slice. FIFO depths must be powers of two, at least 2.
  The register address width is fixed by the RV32I register count.
*/

`ifndef R5P_SETTINGS_SVH
`define R5P_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

`define R5P_XLEN 32          // Data width
`define R5P_AW 5             // Register address width, x0..x31

////////////////////////////////////////////////////////////////////////////
// Flow control
////////////////////////////////////////////////////////////////////////////

// Input FIFO entries, also the credits the source starts with
`define R5P_IN_DEPTH 4
`define R5P_OUT_CREDITS 4    // Credits granted by the sink at reset
`define R5P_RES_DEPTH 2      // Result FIFO entries

`endif

// File: r5p_stream_pkg.sv
/*
  Packet layouts for the instruction stream, the result stream and the
  writeback stage. Widths come from the settings header.
*/

`include "r5p_settings.svh"

package r5p_stream_pkg;

  import r5p_isa_pkg::*;

  // Decoded instruction as it enters the slice
  typedef struct packed {
    logic [7:0]           tag;      // Sequence tag, wraps at 256
    r5p_op_t              op;
    logic [`R5P_AW-1:0]   rd;
    logic [`R5P_AW-1:0]   rs1;
    logic [`R5P_AW-1:0]   rs2;
    logic                 use_imm;  // Immediate replaces rs2
    logic [`R5P_XLEN-1:0] imm;      // Already sign-extended
    logic [`R5P_XLEN-1:0] pc;
  } r5p_instr_t;

  // Result leaving the slice
  typedef struct packed {
    logic [7:0]           tag;
    logic [`R5P_AW-1:0]   rd;
    logic                 wen;      // ALU op with nonzero rd
    logic [`R5P_XLEN-1:0] data;     // Zero for branches
    logic                 taken;
    logic [`R5P_XLEN-1:0] target;
  } r5p_result_t;

  // Writeback stage contents
  typedef struct packed {
    logic [7:0]           tag;
    logic [`R5P_AW-1:0]   rd;
    r5p_op_t              op;
    logic [`R5P_XLEN-1:0] alu_result;
    logic                 taken;
    logic [`R5P_XLEN-1:0] target;
  } r5p_stage_t;

endpackage

// File: r5p_writeback.sv
/*
  Single stage register, rd write, bypass and output credit counter.
  Sink must never return more credits than R5P_OUT_CREDITS.
*/

`timescale 1ns/1ps

`include "r5p_settings.svh"

module r5p_writeback
  import r5p_isa_pkg::*;
  import r5p_stream_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Issue side
  input  logic                 issue_valid,
  input  r5p_instr_t           issue_instr,
  output logic                 issue_ready,
  // Raw register reads and their bypassed versions
  input  logic [`R5P_XLEN-1:0] rs1_raw,
  input  logic [`R5P_XLEN-1:0] rs2_raw,
  output logic [`R5P_XLEN-1:0] rs1_fwd,
  output logic [`R5P_XLEN-1:0] rs2_fwd,
  // Execution results
  input  logic [`R5P_XLEN-1:0] alu_result,
  input  logic                 br_taken,
  input  logic [`R5P_XLEN-1:0] br_target,
  // Register file write
  output logic                 wb_en,
  output logic [`R5P_AW-1:0]   wb_rd,
  output logic [`R5P_XLEN-1:0] wb_data,
  // Result FIFO and output credits
  input  logic                 res_full,
  output logic                 res_push,
  output r5p_result_t          res_data,
  input  logic                 out_fire,
  input  logic                 out_credit,
  output logic                 out_ok
);

  localparam int unsigned CW = $clog2(`R5P_OUT_CREDITS + 1);

  r5p_stage_t    stage;
  logic          stage_valid;
  logic          stage_wen;
  logic          fire;
  logic          issue;
  logic [CW-1:0] out_cnt;            // Credits held from the sink

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////////////////////

  assign fire        = stage_valid & ~res_full;
  assign issue_ready = ~stage_valid | fire;
  assign issue       = issue_valid & issue_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) stage_valid <= 1'b0;
    else if (issue_ready) stage_valid <= issue_valid;   // Refill or drain
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (issue) begin
      stage.tag        <= issue_instr.tag;
      stage.rd         <= issue_instr.rd;
      stage.op         <= issue_instr.op;
      stage.alu_result <= alu_result;
      stage.taken      <= br_taken;
      stage.target     <= br_target;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writeback and bypass
  ////////////////////////////////////////////////////////////////////////////

  assign stage_wen = ~r5p_is_branch(stage.op) & |stage.rd;
  assign wb_en     = fire & stage_wen;   // Same edge as the result push
  assign wb_rd     = stage.rd;
  assign wb_data   = stage.alu_result;

  // Value written this cycle wins over the stale register read
  assign rs1_fwd = (wb_en && issue_instr.rs1 == wb_rd) ? wb_data : rs1_raw;
  assign rs2_fwd = (wb_en && !issue_instr.use_imm && issue_instr.rs2 == wb_rd)
                   ? wb_data : rs2_raw;

  // Result packet
  assign res_push = fire;
  always_comb begin
    res_data.tag    = stage.tag;
    res_data.rd     = stage.rd;
    res_data.wen    = stage_wen;
    res_data.data   = r5p_is_branch(stage.op) ? '0 : stage.alu_result;
    res_data.taken  = stage.taken;
    res_data.target = stage.target;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output credits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) out_cnt <= CW'(`R5P_OUT_CREDITS);
    else out_cnt <= out_cnt + CW'(out_credit) - CW'(out_fire);
  end

  assign out_ok = (out_cnt != '0);

endmodule

// File: verilog.f
+incdir+.
r5p_isa_pkg.sv
r5p_stream_pkg.sv
r5p_credit_fifo.sv
r5p_gpr.sv
r5p_alu.sv
r5p_branch.sv
r5p_writeback.sv
r5p_exec_top.sv
r5p_exec_checker.sv
r5p_exec_tb.sv
